// ==== files.f ====
verilog/fifo_data_pkg.sv
verilog/fifo_ring_pkg.sv
verilog/sync_cell.sv
verilog/slot_stage.sv
verilog/slot_ring_ctrl.sv
verilog/cdc_fifo.sv
tb/cdc_fifo_checker.sv
tb/cdc_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run of the CDC FIFO regression.
TOP := cdc_fifo_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

# The simulator exits nonzero when the testbench ends in $$fatal.
test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f files.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== tb/cdc_fifo_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cdc_fifo_tb;

    import fifo_data_pkg::*;
    import fifo_ring_pkg::*;

    localparam int RCLK_HALF    = 50;
    localparam int WCLK_HALF    = 35;
    localparam int DRIVE_DLY    = 5;             // Input change after the edge.
    localparam int RESET_CYC    = 5;
    localparam int IDLE_CYC     = 20;
    localparam int DIRECTED_CYC = 80;            // Fill, overflow, drain, underflow.
    localparam int RANDOM_CYC   = 1900;
    localparam int TOTAL_CYC    = IDLE_CYC + DIRECTED_CYC + RANDOM_CYC;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYC * 2 * RCLK_HALF;
    localparam logic [15:0] LFSR_SEED = 16'd59568;

    logic  rst_nr;
    logic  wclk;
    logic  writex;
    data_t wdata;
    logic  wfull;
    logic  overflow;
    logic  rclk;
    logic  readx;
    data_t rdata;
    logic  rempty;
    logic  underflow;

    data_t       shadow_q[$];                    // Accepted words, oldest first.
    logic        rand_done;
    logic [15:0] lfsr_state;

    cdc_fifo uut (
        .rst_nr    (rst_nr),
        .wclk      (wclk),
        .writex    (writex),
        .wdata     (wdata),
        .wfull     (wfull),
        .overflow  (overflow),
        .rclk      (rclk),
        .readx     (readx),
        .rdata     (rdata),
        .rempty    (rempty),
        .underflow (underflow)
    );

    always #RCLK_HALF rclk = ~rclk;
    always #WCLK_HALF wclk = ~wclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        abort_run($sformatf("ERROR %s=%h expected=%h", name, got, exp));
    endtask

    // Taps 16, 14, 13, 11 give a maximal sequence.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Called at a wclk edge.
    task automatic sample_write(output logic accepted);
        accepted = writex && !wfull;
        if (accepted) begin
            shadow_q.push_back(wdata);
        end
    endtask

    // Called at an rclk edge.
    task automatic sample_read();
        data_t expected;
        if (readx && !rempty) begin
            assert (shadow_q.size() > 0) else abort_run("read accepted with no word written");
            expected = shadow_q.pop_front();
            assert (rdata === expected) else value_error("rdata", rdata, expected);
        end
    endtask

    task automatic drain_queue();
        while (shadow_q.size() > 0) begin
            @(posedge rclk);
            sample_read();
            #DRIVE_DLY;
            readx = (shadow_q.size() > 0) && !rempty;
        end
    endtask

    task automatic random_writer();
        logic [31:0] bits;
        logic        have_word;
        logic        acc;
        logic        stop;
        have_word = 1'b0;
        stop      = 1'b0;
        while (!stop) begin
            @(posedge wclk);
            sample_write(acc);
            if (acc) begin
                have_word = 1'b0;
            end
            #DRIVE_DLY;
            if (rand_done) begin
                writex = 1'b0;
                stop   = 1'b1;
            end else begin
                if (!have_word) begin
                    draw_bits(3, bits);
                    if (bits[2:0] < 3'd5) begin
                        draw_bits(DATA_W, bits);
                        wdata     = bits;
                        have_word = 1'b1;
                    end
                end
                writex = have_word && !wfull;    // Word is held while full.
            end
        end
    endtask

    task automatic random_reader(input int cycles);
        logic [31:0] bits;
        for (int c = 0; c < cycles; c++) begin
            @(posedge rclk);
            sample_read();
            #DRIVE_DLY;
            draw_bits(2, bits);
            readx = (bits[1:0] != 2'b00) && !rempty;
        end
        @(posedge rclk);
        sample_read();
        #DRIVE_DLY;
        readx     = 1'b0;
        rand_done = 1'b1;
    endtask

    initial begin
        #WATCHDOG_NS;
        abort_run("watchdog expired before the tests finished");
    end

    always @(negedge rclk) begin
        if (uut.u_chk.wr_fail_cnt + uut.u_chk.rd_fail_cnt != 0) begin
            abort_run("a protocol assertion in the checker failed");
        end
    end

    initial begin
        logic        acc;
        logic [31:0] bits;
        rclk        = 1'b0;
        wclk        = 1'b0;
        rst_nr      = 1'b0;
        writex      = 1'b0;
        readx       = 1'b0;
        wdata       = '0;
        rand_done   = 1'b0;
        lfsr_state  = LFSR_SEED;
        repeat (RESET_CYC) @(posedge rclk);
        #DRIVE_DLY;
        rst_nr = 1'b1;

        repeat (IDLE_CYC) @(posedge rclk);
        assert (rempty === 1'b1) else value_error("rempty", 32'(rempty), 32'h1);
        assert (wfull === 1'b0) else value_error("wfull", 32'(wfull), 32'h0);

        // Fill with reads held off.
        @(posedge wclk);
        #DRIVE_DLY;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            draw_bits(DATA_W, bits);
            wdata  = bits;
            writex = 1'b1;
            @(posedge wclk);
            assert (!wfull) else abort_run($sformatf("wfull high after only %0d writes", i));
            sample_write(acc);
            #DRIVE_DLY;
        end
        writex = 1'b0;
        @(posedge wclk);
        assert (wfull === 1'b1) else value_error("wfull", 32'(wfull), 32'h1);

        // One write into the full ring.
        #DRIVE_DLY;
        draw_bits(DATA_W, bits);
        wdata  = bits;
        writex = 1'b1;
        @(posedge wclk);
        sample_write(acc);
        assert (!acc) else abort_run("write was accepted while full");
        #DRIVE_DLY;
        writex = 1'b0;
        @(posedge wclk);
        assert (overflow === 1'b1) else value_error("overflow", 32'(overflow), 32'h1);

        drain_queue();
        @(posedge rclk);
        assert (rempty === 1'b1) else value_error("rempty", 32'(rempty), 32'h1);

        // One read from the empty ring.
        #DRIVE_DLY;
        readx = 1'b1;
        @(posedge rclk);
        sample_read();
        #DRIVE_DLY;
        readx = 1'b0;
        @(posedge rclk);
        assert (underflow === 1'b1) else value_error("underflow", 32'(underflow), 32'h1);

        fork
            random_writer();
            random_reader(RANDOM_CYC);
        join
        drain_queue();
        @(posedge rclk);
        assert (rempty === 1'b1) else value_error("rempty", 32'(rempty), 32'h1);
        assert (overflow === 1'b1) else value_error("overflow", 32'(overflow), 32'h1);
        assert (underflow === 1'b1) else value_error("underflow", 32'(underflow), 32'h1);

        @(negedge rclk);
        if (uut.u_chk.wr_fail_cnt + uut.u_chk.rd_fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("a protocol assertion in the checker failed");
        end
    end

endmodule

`default_nettype wire

// ==== tb/cdc_fifo_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cdc_fifo_checker (
    input logic wclk,
    input logic rst_nw,
    input logic writex,
    input logic wfull,
    input logic overflow,

    input logic rclk,
    input logic rst_nrs,
    input logic readx,
    input logic rempty,
    input logic underflow
);

    int wr_fail_cnt = 0;                        // Failures seen on the write side.
    int rd_fail_cnt = 0;                        // Failures seen on the read side.

    // Flags while each domain is held in reset.
    a_wr_reset: assert property (@(posedge wclk) !rst_nw |-> !wfull && !overflow)
        else begin
            wr_fail_cnt++;
            $error("write side flags wrong in reset");
        end
    a_rd_reset: assert property (@(posedge rclk) !rst_nrs |-> rempty && !underflow)
        else begin
            rd_fail_cnt++;
            $error("read side flags wrong in reset");
        end

    a_overflow_set: assert property (@(posedge wclk) disable iff (!rst_nw)
        writex && wfull |=> overflow)
        else begin
            wr_fail_cnt++;
            $error("overflow missed a write into a full FIFO");
        end
    a_overflow_sticky: assert property (@(posedge wclk) disable iff (!rst_nw)
        overflow |=> overflow)
        else begin
            wr_fail_cnt++;
            $error("overflow fell before reset");
        end
    // Only a write can make the ring full.
    a_wfull_hold: assert property (@(posedge wclk) disable iff (!rst_nw)
        !wfull && !writex |=> !wfull)
        else begin
            wr_fail_cnt++;
            $error("wfull rose without a write");
        end

    a_underflow_set: assert property (@(posedge rclk) disable iff (!rst_nrs)
        readx && rempty |=> underflow)
        else begin
            rd_fail_cnt++;
            $error("underflow missed a read from an empty FIFO");
        end
    a_underflow_sticky: assert property (@(posedge rclk) disable iff (!rst_nrs)
        underflow |=> underflow)
        else begin
            rd_fail_cnt++;
            $error("underflow fell before reset");
        end
    a_rempty_hold: assert property (@(posedge rclk) disable iff (!rst_nrs)
        !rempty && !readx |=> !rempty)
        else begin
            rd_fail_cnt++;
            $error("rempty rose without a read");
        end

endmodule

bind cdc_fifo cdc_fifo_checker u_chk (
    .wclk      (wclk),
    .rst_nw    (rst_nw),
    .writex    (writex),
    .wfull     (wfull),
    .overflow  (overflow),
    .rclk      (rclk),
    .rst_nrs   (rst_nrs),
    .readx     (readx),
    .rempty    (rempty),
    .underflow (underflow)
);

`default_nettype wire

// ==== verilog/cdc_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module cdc_fifo (
    input  logic                  rst_nr,

    input  logic                  wclk,
    input  logic                  writex,
    input  fifo_data_pkg::data_t  wdata,
    output logic                  wfull,
    output logic                  overflow,

    input  logic                  rclk,
    input  logic                  readx,
    output fifo_data_pkg::data_t  rdata,
    output logic                  rempty,
    output logic                  underflow
);

    import fifo_data_pkg::*;
    import fifo_ring_pkg::*;

    logic      rst_nw;                          // Reset released in wclk.
    logic      rst_nrs;                         // Reset released in rclk.
    slot_vec_t slot_write;
    slot_vec_t slot_read;
    slot_vec_t slot_full;
    slot_vec_t slot_empty;
    slot_idx_t rd_sel;
    data_t     slot_data [NUM_SLOTS];

    sync_cell u_wrst_sync (
        .clk   (wclk),
        .rst_n (rst_nr),
        .din   (1'b1),
        .dout  (rst_nw)
    );

    sync_cell u_rrst_sync (
        .clk   (rclk),
        .rst_n (rst_nr),
        .din   (1'b1),
        .dout  (rst_nrs)
    );

    slot_ring_ctrl u_ctrl (
        .wclk       (wclk),
        .rst_nw     (rst_nw),
        .writex     (writex),
        .wfull      (wfull),
        .overflow   (overflow),
        .slot_write (slot_write),
        .slot_full  (slot_full),
        .rclk       (rclk),
        .rst_nrs    (rst_nrs),
        .readx      (readx),
        .rempty     (rempty),
        .underflow  (underflow),
        .slot_read  (slot_read),
        .slot_empty (slot_empty),
        .rd_sel     (rd_sel)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        slot_stage u_slot (
            .wclk    (wclk),
            .rst_nw  (rst_nw),
            .writex  (slot_write[i]),
            .wdata   (wdata),
            .wfull   (slot_full[i]),
            .rclk    (rclk),
            .rst_nrs (rst_nrs),
            .readx   (slot_read[i]),
            .rdata   (slot_data[i]),
            .rempty  (slot_empty[i])
        );
    end

    // Head word of the ring.
    always_comb begin
        rdata = slot_data[0];
        for (int i = 1; i < NUM_SLOTS; i++) begin
            if (rd_sel == slot_idx_t'(i)) begin
                rdata = slot_data[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/slot_ring_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module slot_ring_ctrl (
    input  logic                      wclk,
    input  logic                      rst_nw,
    input  logic                      writex,
    output logic                      wfull,
    output logic                      overflow,
    output fifo_ring_pkg::slot_vec_t  slot_write,
    input  fifo_ring_pkg::slot_vec_t  slot_full,

    input  logic                      rclk,
    input  logic                      rst_nrs,
    input  logic                      readx,
    output logic                      rempty,
    output logic                      underflow,
    output fifo_ring_pkg::slot_vec_t  slot_read,
    input  fifo_ring_pkg::slot_vec_t  slot_empty,
    output fifo_ring_pkg::slot_idx_t  rd_sel
);

    import fifo_ring_pkg::*;

    slot_idx_t wptr;
    slot_idx_t rptr;
    logic      write_ok;                        // Accepted write this edge.
    logic      read_ok;                         // Accepted read this edge.

    function automatic slot_idx_t ptr_next(input slot_idx_t ptr);
        slot_idx_t nxt;
        if (ptr == slot_idx_t'(NUM_SLOTS - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + slot_idx_t'(1);
        end
        return nxt;
    endfunction

    // Flags come from the slot under each pointer.
    assign wfull  = slot_full[wptr];
    assign rempty = slot_empty[rptr];

    assign write_ok = writex && !wfull;
    assign read_ok  = readx && !rempty;

    assign slot_write = write_ok ? (slot_vec_t'(1) << wptr) : '0;
    assign slot_read  = read_ok ? (slot_vec_t'(1) << rptr) : '0;
    assign rd_sel     = rptr;

    always_ff @(posedge wclk or negedge rst_nw) begin
        if (!rst_nw) begin
            wptr <= '0;
        end else if (write_ok) begin
            wptr <= ptr_next(wptr);
        end
    end

    always_ff @(posedge rclk or negedge rst_nrs) begin
        if (!rst_nrs) begin
            rptr <= '0;
        end else if (read_ok) begin
            rptr <= ptr_next(rptr);
        end
    end

    // Sticky until the next reset.
    always_ff @(posedge wclk or negedge rst_nw) begin
        if (!rst_nw) begin
            overflow <= 1'b0;
        end else if (writex && wfull) begin
            overflow <= 1'b1;                   // Write into a full ring.
        end
    end

    always_ff @(posedge rclk or negedge rst_nrs) begin
        if (!rst_nrs) begin
            underflow <= 1'b0;
        end else if (readx && rempty) begin
            underflow <= 1'b1;                  // Read from an empty ring.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/slot_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module slot_stage (
    input  logic                  wclk,
    input  logic                  rst_nw,
    input  logic                  writex,
    input  fifo_data_pkg::data_t  wdata,
    output logic                  wfull,

    input  logic                  rclk,
    input  logic                  rst_nrs,
    input  logic                  readx,
    output fifo_data_pkg::data_t  rdata,
    output logic                  rempty
);

    import fifo_data_pkg::*;

    data_t data_q;                              // Slot storage.
    logic  wtok;                                // Flips on each write.
    logic  rtok;                                // Flips on each read.
    logic  wtok_r;                              // Write token seen in rclk.
    logic  rtok_w;                              // Read token seen in wclk.

    // Storage holds the word from the write edge on.
    always_ff @(posedge wclk) begin
        if (writex) begin
            data_q <= wdata;
        end
    end

    always_ff @(posedge wclk or negedge rst_nw) begin
        if (!rst_nw) begin
            wtok <= 1'b0;
        end else if (writex) begin
            wtok <= ~wtok;
        end
    end

    always_ff @(posedge rclk or negedge rst_nrs) begin
        if (!rst_nrs) begin
            rtok <= 1'b0;
        end else if (readx) begin
            rtok <= ~rtok;
        end
    end

    sync_cell u_wtok_sync (
        .clk   (rclk),
        .rst_n (rst_nrs),
        .din   (wtok),
        .dout  (wtok_r)
    );

    sync_cell u_rtok_sync (
        .clk   (wclk),
        .rst_n (rst_nw),
        .din   (rtok),
        .dout  (rtok_w)
    );

    // Tokens differ while a word sits in the slot.
    assign wfull  = wtok != rtok_w;             // Reader has not freed it yet.
    assign rempty = rtok == wtok_r;             // Write not yet visible.
    assign rdata  = data_q;

endmodule

`default_nettype wire

// ==== verilog/sync_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_cell #(
    parameter int STAGES = fifo_ring_pkg::SYNC_STAGES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic din,
    output logic dout
);

    logic [STAGES-1:0] sync_q;                  // Shift chain, index 0 first.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], din};
        end
    end

    // With din tied high the chain becomes a reset release.
    assign dout = sync_q[STAGES-1];

endmodule

`default_nettype wire

// ==== verilog/fifo_ring_pkg.sv ====
`default_nettype none

// Geometry of the slot ring and depth of the token synchronizers.
package fifo_ring_pkg;

    localparam int NUM_SLOTS   = 5;                     // FIFO capacity.
    localparam int SLOT_IDX_W  = $clog2(NUM_SLOTS);     // Pointer width.
    localparam int SYNC_STAGES = 2;                     // Flops per crossing.

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;          // Ring pointer.
    typedef logic [NUM_SLOTS-1:0]  slot_vec_t;          // One bit per slot.

endpackage

`default_nettype wire

// ==== verilog/fifo_data_pkg.sv ====
`default_nettype none

// Word format carried through the clock-domain-crossing FIFO.
package fifo_data_pkg;

    localparam int DATA_W = 32;                 // Payload width.

    typedef logic [DATA_W-1:0] data_t;          // One FIFO word.

endpackage

`default_nettype wire
